// File: run.sh
#!/bin/sh
# Build the response bank testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_resp_bank -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qxF '*** PASSED ***'; then
  exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

// File: src.f
+incdir+src
src/resp_bank_pkg.sv
src/slot_allocator.sv
src/link_table.sv
src/list_ctrl.sv
src/payload_store.sv
src/release_sel.sv
src/resp_bank_top.sv
verif/tb_resp_bank.sv

// File: src/link_table.sv
// Next-pointer table with one write port and two combinational read ports
`include "resp_bank_macros.svh"

module link_table import resp_bank_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  link_wr_t              i_wr,
  input  logic [`RB_ADDR_W-1:0] i_fill_addr,
  input  logic [`RB_ADDR_W-1:0] i_pop_addr,
  output logic [`RB_ADDR_W-1:0] o_fill_next,
  output logic [`RB_ADDR_W-1:0] o_pop_next
);

  // Entry a holds the cell that follows cell a in its identifier's list
  logic [`RB_DEPTH-1:0][`RB_ADDR_W-1:0] next_q;

  //////////////////////
  // Write port
  //////////////////////

  // Written on reservation, from the previous last reserved cell to the new one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      next_q <= '0;
    end else if (i_wr.en) begin
      next_q[i_wr.addr] <= i_wr.next;
    end
  end

  //////////////////////
  // Read ports
  //////////////////////

  // Input side follows the link from the current fill pointer
  assign o_fill_next = next_q[i_fill_addr];

  // Output side follows the link from the current out pointer
  // Both reads are combinational so the pointers move in the same cycle
  assign o_pop_next = next_q[i_pop_addr];

endmodule

// File: src/list_ctrl.sv
// Per-identifier list pointers and counters, reservation linking, input acceptance and pop
`include "resp_bank_macros.svh"

module list_ctrl import resp_bank_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  rsv_req_t              i_rsv,
  input  logic                  i_rsv_fire,
  input  logic [`RB_ADDR_W-1:0] i_rsv_addr,
  input  resp_t                 i_in_rsp,
  input  logic                  i_in_valid,
  output logic                  o_in_ready,
  input  pop_req_t              i_pop,
  output store_wr_t             o_store_wr,
  output id_addr_vec_t          o_out_ptrs,
  output id_cnt_vec_t           o_filled_cnt
);

  // Last reserved cell, next cell to take a response and oldest filled cell
  id_addr_vec_t last_q, last_d;
  id_addr_vec_t fill_q, fill_d;
  id_addr_vec_t out_q, out_d;

  // Reserved cells without a response, and cells holding one
  id_cnt_vec_t unfilled_q, unfilled_d;
  id_cnt_vec_t filled_q, filled_d;

  logic [`RB_NUM_IDS-1:0] in_hit;
  logic [`RB_NUM_IDS-1:0] in_take;
  logic [`RB_NUM_IDS-1:0] rsv_take;
  logic [`RB_NUM_IDS-1:0] pop_take;
  logic                   in_fire;
  logic [`RB_ADDR_W-1:0]  fill_next;
  logic [`RB_ADDR_W-1:0]  pop_next;
  link_wr_t               link_wr;

  //////////////////////
  // Event decoding
  //////////////////////

  always_comb begin
    for (int i = 0; i < `RB_NUM_IDS; i++) begin
      // A response is only taken when its identifier has an open reservation
      in_hit[i]   = (i_in_rsp.id == `RB_ID_W'(i)) && (unfilled_q[i] != '0);
      rsv_take[i] = i_rsv_fire && i_rsv.id_onehot[i];
      pop_take[i] = i_pop.en && (i_pop.id == `RB_ID_W'(i));
    end
  end

  // Ready looks at valid, as the controller side allows it
  assign o_in_ready = i_in_valid && |in_hit;
  assign in_fire    = i_in_valid && o_in_ready;
  assign in_take    = in_fire ? in_hit : '0;

  //////////////////////
  // Linking
  //////////////////////

  // Only a list that still holds cells gets a new link
  // A fresh list has no predecessor, and its stale last pointer may name another list's cell
  always_comb begin
    link_wr = '0;
    for (int i = 0; i < `RB_NUM_IDS; i++) begin
      if (rsv_take[i] && (unfilled_q[i] != '0 || filled_q[i] != '0)) begin
        link_wr.en   = 1'b1;
        link_wr.addr = last_q[i];
        link_wr.next = i_rsv_addr;
      end
    end
  end

  link_table i_link_table (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .i_wr       (link_wr),
    .i_fill_addr(fill_q[i_in_rsp.id]),
    .i_pop_addr (out_q[i_pop.id]),
    .o_fill_next(fill_next),
    .o_pop_next (pop_next)
  );

  // The payload lands in the cell at the fill pointer of its identifier
  assign o_store_wr.en      = in_fire;
  assign o_store_wr.addr    = fill_q[i_in_rsp.id];
  assign o_store_wr.payload = i_in_rsp.payload;

  //////////////////////
  // Pointer update
  //////////////////////

  always_comb begin
    last_d     = last_q;
    fill_d     = fill_q;
    out_d      = out_q;
    unfilled_d = unfilled_q;
    filled_d   = filled_q;
    for (int i = 0; i < `RB_NUM_IDS; i++) begin
      if (rsv_take[i]) begin
        last_d[i] = i_rsv_addr;
      end
      unfilled_d[i] = unfilled_q[i] + `RB_CNT_W'(rsv_take[i]) - `RB_CNT_W'(in_take[i]);
      filled_d[i]   = filled_q[i] + `RB_CNT_W'(in_take[i]) - `RB_CNT_W'(pop_take[i]);

      // With no open reservation left, the new cell becomes the fill target directly
      // This also covers the link being written in this very cycle
      if (rsv_take[i] && (unfilled_q[i] == `RB_CNT_W'(in_take[i]))) begin
        fill_d[i] = i_rsv_addr;
      end else if (in_take[i]) begin
        fill_d[i] = fill_next;
      end

      // The first filled cell of an empty list is the new oldest one
      if (in_take[i] && (filled_q[i] == `RB_CNT_W'(pop_take[i]))) begin
        out_d[i] = fill_q[i];
      end else if (pop_take[i]) begin
        out_d[i] = pop_next;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q     <= '0;
      fill_q     <= '0;
      out_q      <= '0;
      unfilled_q <= '0;
      filled_q   <= '0;
    end else begin
      last_q     <= last_d;
      fill_q     <= fill_d;
      out_q      <= out_d;
      unfilled_q <= unfilled_d;
      filled_q   <= filled_d;
    end
  end

  assign o_out_ptrs   = out_q;
  assign o_filled_cnt = filled_q;

endmodule

// File: src/payload_store.sv
// Payload memory with a write port and a registered read port
`include "resp_bank_macros.svh"

module payload_store import resp_bank_pkg::*; (
  input  logic                     clk_i,
  input  store_wr_t                i_wr,
  input  logic [`RB_ADDR_W-1:0]    i_rd_addr,
  output logic [`RB_PAYLOAD_W-1:0] o_rd_payload
);

  // One response code per cell
  logic [`RB_PAYLOAD_W-1:0] mem_q [`RB_DEPTH];

  // Read data register, follows the read address one cycle later
  logic [`RB_PAYLOAD_W-1:0] rd_q;

  //////////////////////
  // Write port
  //////////////////////

  // A cell is written once per occupancy, by the input handshake
  always_ff @(posedge clk_i) begin
    if (i_wr.en) begin
      mem_q[i_wr.addr] <= i_wr.payload;
    end
  end

  //////////////////////
  // Read port
  //////////////////////

  // Reading every cycle is fine
  // While the output stalls the address stays on a cell that cannot be rewritten
  always_ff @(posedge clk_i) begin
    rd_q <= mem_q[i_rd_addr];
  end

  assign o_rd_payload = rd_q;

endmodule

// File: src/release_sel.sv
// Release-enable filtering, lowest-identifier arbitration and the output register
`include "resp_bank_macros.svh"

module release_sel import resp_bank_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  id_addr_vec_t             i_out_ptrs,
  input  id_cnt_vec_t              i_filled_cnt,
  input  logic [`RB_DEPTH-1:0]     i_release_en,
  input  logic                     i_out_ready,
  input  logic [`RB_PAYLOAD_W-1:0] i_rd_payload,
  output pop_req_t                 o_pop,
  output logic [`RB_ADDR_W-1:0]    o_rd_addr,
  output resp_t                    o_out_rsp,
  output logic                     o_out_valid,
  output logic                     o_out_fire,
  output logic [`RB_ADDR_W-1:0]    o_out_addr
);

  logic [`RB_NUM_IDS-1:0] eligible;
  logic                   win_any;
  logic [`RB_ID_W-1:0]    win_id;
  logic                   can_load;
  logic                   sel;

  // Output register holds identifier and cell, payload comes from the store
  logic                  valid_q;
  logic [`RB_ID_W-1:0]   id_q;
  logic [`RB_ADDR_W-1:0] addr_q;

  //////////////////////
  // Arbitration
  //////////////////////

  // Only the oldest filled cell of a list may leave, and only once released
  always_comb begin
    for (int i = 0; i < `RB_NUM_IDS; i++) begin
      eligible[i] = (i_filled_cnt[i] != '0) && i_release_en[i_out_ptrs[i]];
    end
  end

  // Scanning downwards leaves the lowest eligible identifier as winner
  always_comb begin
    win_any = 1'b0;
    win_id  = '0;
    for (int i = `RB_NUM_IDS - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        win_any = 1'b1;
        win_id  = `RB_ID_W'(i);
      end
    end
  end

  // The register takes a new item when empty or being emptied this cycle
  assign o_out_fire = valid_q && i_out_ready;
  assign can_load   = !valid_q || i_out_ready;
  assign sel        = win_any && can_load;

  // Selection unlinks the cell from its list right away
  assign o_pop.en = sel;
  assign o_pop.id = win_id;

  // Without a selection the store keeps reading the cell already at the output
  assign o_rd_addr = sel ? i_out_ptrs[win_id] : addr_q;

  //////////////////////
  // Output register
  //////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      id_q    <= '0;
      addr_q  <= '0;
    end else begin
      if (can_load) begin
        valid_q <= sel;
      end
      if (sel) begin
        id_q   <= win_id;
        addr_q <= i_out_ptrs[win_id];
      end
    end
  end

  assign o_out_valid       = valid_q;
  assign o_out_rsp.id      = id_q;
  assign o_out_rsp.payload = i_rd_payload;
  assign o_out_addr        = addr_q;

endmodule

// File: src/resp_bank_macros.svh
// Fixed sizes of the response bank: identifiers, cells, addresses, counters and payload
`ifndef RESP_BANK_MACROS_SVH
`define RESP_BANK_MACROS_SVH

// Number of AXI write identifiers, each with its own queue
`define RB_NUM_IDS 4

// Width of an AXI identifier
`define RB_ID_W 2

// Number of cells in the shared pool
`define RB_DEPTH 8

// Width of a cell address, which doubles as the internal identifier
`define RB_ADDR_W 3

// Width of a per-identifier counter, wide enough to count every cell
`define RB_CNT_W 4

// Width of the stored payload, the AXI write response code
`define RB_PAYLOAD_W 2

`endif

// File: src/resp_bank_pkg.sv
// Packed struct and vector types shared by the response bank RTL and its testbench
`include "resp_bank_macros.svh"

package resp_bank_pkg;

  // One write response, identifier in the upper bits and response code below it
  typedef struct packed {
    logic [`RB_ID_W-1:0]      id;
    logic [`RB_PAYLOAD_W-1:0] payload;
  } resp_t;

  // Reservation request with a one-hot identifier
  typedef struct packed {
    logic [`RB_NUM_IDS-1:0] id_onehot;
    logic                   valid;
  } rsv_req_t;

  // Write into the next-pointer table, linking addr to next
  typedef struct packed {
    logic                 en;
    logic [`RB_ADDR_W-1:0] addr;
    logic [`RB_ADDR_W-1:0] next;
  } link_wr_t;

  // Order from the output side to unlink the oldest filled cell of one identifier
  typedef struct packed {
    logic                en;
    logic [`RB_ID_W-1:0] id;
  } pop_req_t;

  // Write into the payload memory
  typedef struct packed {
    logic                     en;
    logic [`RB_ADDR_W-1:0]     addr;
    logic [`RB_PAYLOAD_W-1:0] payload;
  } store_wr_t;

  // One cell address and one counter per identifier
  typedef logic [`RB_NUM_IDS-1:0][`RB_ADDR_W-1:0] id_addr_vec_t;
  typedef logic [`RB_NUM_IDS-1:0][`RB_CNT_W-1:0]  id_cnt_vec_t;

endpackage

// File: src/resp_bank_top.sv
// Response bank top level joining reservation, list control, payload memory and output side
`include "resp_bank_macros.svh"

module resp_bank_top import resp_bank_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Reservation side
  input  rsv_req_t              i_rsv,
  output logic                  o_rsv_ready,
  output logic [`RB_ADDR_W-1:0] o_rsv_iid,
  // Responses from the real controller
  input  resp_t                 i_in_rsp,
  input  logic                  i_in_valid,
  output logic                  o_in_ready,
  // Releaser
  input  logic [`RB_DEPTH-1:0]  i_release_en,
  output logic [`RB_DEPTH-1:0]  o_released_onehot,
  // Requester
  output resp_t                 o_out_rsp,
  output logic                  o_out_valid,
  input  logic                  i_out_ready
);

  logic                     rsv_fire;
  store_wr_t                store_wr;
  id_addr_vec_t             out_ptrs;
  id_cnt_vec_t              filled_cnt;
  pop_req_t                 pop;
  logic [`RB_ADDR_W-1:0]    rd_addr;
  logic [`RB_PAYLOAD_W-1:0] rd_payload;
  logic                     out_fire;
  logic [`RB_ADDR_W-1:0]    out_addr;

  //////////////////////
  // Input side
  //////////////////////

  slot_allocator i_slot_allocator (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .i_rsv            (i_rsv),
    .i_out_fire       (out_fire),
    .i_out_addr       (out_addr),
    .o_rsv_ready      (o_rsv_ready),
    .o_rsv_iid        (o_rsv_iid),
    .o_rsv_fire       (rsv_fire),
    .o_released_onehot(o_released_onehot)
  );

  // The reserved address is the lowest free one shown on o_rsv_iid
  list_ctrl i_list_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .i_rsv       (i_rsv),
    .i_rsv_fire  (rsv_fire),
    .i_rsv_addr  (o_rsv_iid),
    .i_in_rsp    (i_in_rsp),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .i_pop       (pop),
    .o_store_wr  (store_wr),
    .o_out_ptrs  (out_ptrs),
    .o_filled_cnt(filled_cnt)
  );

  //////////////////////
  // Output side
  //////////////////////

  payload_store i_payload_store (
    .clk_i       (clk_i),
    .i_wr        (store_wr),
    .i_rd_addr   (rd_addr),
    .o_rd_payload(rd_payload)
  );

  release_sel i_release_sel (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .i_out_ptrs  (out_ptrs),
    .i_filled_cnt(filled_cnt),
    .i_release_en(i_release_en),
    .i_out_ready (i_out_ready),
    .i_rd_payload(rd_payload),
    .o_pop       (pop),
    .o_rd_addr   (rd_addr),
    .o_out_rsp   (o_out_rsp),
    .o_out_valid (o_out_valid),
    .o_out_fire  (out_fire),
    .o_out_addr  (out_addr)
  );

endmodule

// File: src/slot_allocator.sv
// Cell valid bits, lowest free address search, reservation ready and one-hot release report
`include "resp_bank_macros.svh"

module slot_allocator import resp_bank_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  rsv_req_t              i_rsv,
  input  logic                  i_out_fire,
  input  logic [`RB_ADDR_W-1:0] i_out_addr,
  output logic                  o_rsv_ready,
  output logic [`RB_ADDR_W-1:0] o_rsv_iid,
  output logic                  o_rsv_fire,
  output logic [`RB_DEPTH-1:0]  o_released_onehot
);

  // A set bit marks a cell that is reserved, filled or waiting at the output
  logic [`RB_DEPTH-1:0] valid_q;
  logic [`RB_DEPTH-1:0] valid_d;
  logic [`RB_DEPTH-1:0] rsv_mask;
  logic [`RB_DEPTH-1:0] out_mask;
  logic [`RB_ADDR_W-1:0] free_addr;

  //////////////////////
  // Free cell search
  //////////////////////

  // Scan from the top so the lowest clear bit is the last one written
  always_comb begin
    free_addr = '0;
    for (int a = `RB_DEPTH - 1; a >= 0; a--) begin
      if (!valid_q[a]) begin
        free_addr = `RB_ADDR_W'(a);
      end
    end
  end

  // Reservations are possible as long as one cell is still clear
  assign o_rsv_ready = ~&valid_q;
  assign o_rsv_iid   = free_addr;
  assign o_rsv_fire  = i_rsv.valid && o_rsv_ready;

  //////////////////////
  // Valid bit update
  //////////////////////

  // A reservation only hits a clear cell and a release only hits a set one
  assign rsv_mask = o_rsv_fire ? (`RB_DEPTH'(1) << free_addr) : '0;
  assign out_mask = i_out_fire ? (`RB_DEPTH'(1) << i_out_addr) : '0;
  assign valid_d  = (valid_q | rsv_mask) & ~out_mask;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // The released cell is reported in the cycle of its output handshake
  assign o_released_onehot = out_mask;

endmodule

// File: verif/tb_resp_bank.sv
// Response bank testbench with clock, stimulus, reference cell model, checker and watchdog
`include "resp_bank_macros.svh"

module tb_resp_bank import resp_bank_pkg::*; ();

  localparam int NUM_RAND   = 300;
  localparam int NUM_OPS    = NUM_RAND + 100;
  localparam int CLK_PERIOD = 20;

  logic                  clk_i;
  logic                  rst_ni;
  rsv_req_t              i_rsv;
  logic                  o_rsv_ready;
  logic [`RB_ADDR_W-1:0] o_rsv_iid;
  resp_t                 i_in_rsp;
  logic                  i_in_valid;
  logic                  o_in_ready;
  logic [`RB_DEPTH-1:0]  i_release_en;
  logic [`RB_DEPTH-1:0]  o_released_onehot;
  resp_t                 o_out_rsp;
  logic                  o_out_valid;
  logic                  i_out_ready;

  // Reference model with one record per cell and list order given by the reservation sequence number
  bit cell_busy     [`RB_DEPTH];
  bit cell_filled   [`RB_DEPTH];
  bit cell_rel_seen [`RB_DEPTH];
  int cell_id       [`RB_DEPTH];
  int cell_pay      [`RB_DEPTH];
  int cell_seq      [`RB_DEPTH];
  int seq_ctr;

  int          errors;
  int          checks;
  int          outputs;
  logic [31:0] rand_state;
  bit          stall_q;
  resp_t       stall_rsp;

  resp_bank_top i_resp_bank_top (.*);

  //////////////////////
  // Helpers
  //////////////////////

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rand_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rand_state = x;
    return x;
  endfunction

  function automatic int lowest_free();
    for (int a = 0; a < `RB_DEPTH; a++) begin
      if (!cell_busy[a]) begin
        return a;
      end
    end
    return -1;
  endfunction

  // Oldest cell of an identifier's list, or its oldest cell still waiting for a response
  function automatic int oldest_cell(input int id, input bit unfilled_only);
    int best;
    best = -1;
    for (int a = 0; a < `RB_DEPTH; a++) begin
      if (cell_busy[a] && cell_id[a] == id && !(unfilled_only && cell_filled[a])) begin
        if (best < 0 || cell_seq[a] < cell_seq[best]) begin
          best = a;
        end
      end
    end
    return best;
  endfunction

  // Expected response and cell for an output of this identifier
  function automatic bit expected_output(input int id, output resp_t rsp, output int addr);
    addr        = oldest_cell(id, 1'b0);
    rsp.id      = `RB_ID_W'(id);
    rsp.payload = '0;
    if (addr < 0) begin
      return 1'b0;
    end
    rsp.payload = `RB_PAYLOAD_W'(cell_pay[addr]);
    return cell_filled[addr];
  endfunction

  function automatic int onehot_index(input logic [`RB_NUM_IDS-1:0] onehot);
    int idx;
    idx = 0;
    for (int i = 0; i < `RB_NUM_IDS; i++) begin
      if (onehot[i]) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  function automatic int busy_count();
    int n;
    n = 0;
    for (int a = 0; a < `RB_DEPTH; a++) begin
      n += int'(cell_busy[a]);
    end
    return n;
  endfunction

  task automatic expect_true(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("Fail %0t: %s", $time, what);
    end
  endtask

  // Inputs change a little after the rising edge
  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic reserve(input int id);
    i_rsv.id_onehot = `RB_NUM_IDS'(1) << id;
    i_rsv.valid     = 1'b1;
    do begin
      @(negedge clk_i);
    end while (!o_rsv_ready);
    step();
    i_rsv = '0;
  endtask

  task automatic send_rsp(input int id, input logic [`RB_PAYLOAD_W-1:0] pay);
    i_in_rsp.id      = `RB_ID_W'(id);
    i_in_rsp.payload = pay;
    i_in_valid       = 1'b1;
    do begin
      @(negedge clk_i);
    end while (!o_in_ready);
    step();
    i_in_valid = 1'b0;
  endtask

  //////////////////////
  // Clock and watchdog
  //////////////////////

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(NUM_OPS * 40 * CLK_PERIOD);
    $display("Timeout: the run did not complete in time, %0d errors so far", errors);
    $display("*** FAILED ***");
    $finish;
  end

  //////////////////////
  // Checker
  //////////////////////

  // Sampled mid-cycle, where every handshake input is stable until the next rising edge
  always @(negedge clk_i) begin
    resp_t exp_rsp;
    int    exp_addr;
    int    free_addr;
    int    fill_addr;
    bit    found;
    bit    out_fire;
    fill_addr = -1;
    found     = 1'b0;
    out_fire  = o_out_valid && i_out_ready;
    if (rst_ni) begin
      // A stalled output keeps its word and its valid
      if (stall_q) begin
        expect_true(o_out_valid && o_out_rsp == stall_rsp, "output changed during back-pressure");
      end
      for (int a = 0; a < `RB_DEPTH; a++) begin
        if (cell_busy[a] && cell_filled[a] && i_release_en[a]) begin
          cell_rel_seen[a] = 1'b1;
        end
      end
      free_addr = lowest_free();
      expect_true(o_rsv_ready == (free_addr >= 0),
                  $sformatf("o_rsv_ready is %b with lowest free cell %0d", o_rsv_ready, free_addr));
      if (free_addr >= 0) begin
        expect_true(int'(o_rsv_iid) == free_addr,
                    $sformatf("o_rsv_iid is %0d, expected %0d", o_rsv_iid, free_addr));
      end
      if (i_in_valid) begin
        fill_addr = oldest_cell(int'(i_in_rsp.id), 1'b1);
        expect_true(o_in_ready == (fill_addr >= 0),
                    $sformatf("o_in_ready is %b for id %0d", o_in_ready, i_in_rsp.id));
      end
      if (out_fire) begin
        found = expected_output(int'(o_out_rsp.id), exp_rsp, exp_addr);
        expect_true(found && o_out_rsp == exp_rsp,
                    $sformatf("output id %0d payload %0d, expected payload %0d",
                              o_out_rsp.id, o_out_rsp.payload, exp_rsp.payload));
        if (found) begin
          expect_true(o_released_onehot == (`RB_DEPTH'(1) << exp_addr),
                      $sformatf("o_released_onehot %b, expected cell %0d",
                                o_released_onehot, exp_addr));
          expect_true(cell_rel_seen[exp_addr], "a cell left before its release enable was set");
        end
      end else begin
        expect_true(o_released_onehot == '0, "o_released_onehot pulsed without an output");
      end

      // The model is updated after every check has seen the state before this edge
      if (i_rsv.valid && o_rsv_ready && free_addr >= 0) begin
        cell_busy[free_addr]     = 1'b1;
        cell_filled[free_addr]   = 1'b0;
        cell_rel_seen[free_addr] = 1'b0;
        cell_id[free_addr]       = onehot_index(i_rsv.id_onehot);
        cell_seq[free_addr]      = seq_ctr;
        seq_ctr++;
      end
      if (i_in_valid && o_in_ready && fill_addr >= 0) begin
        cell_filled[fill_addr] = 1'b1;
        cell_pay[fill_addr]    = int'(i_in_rsp.payload);
      end
      if (out_fire && found) begin
        cell_busy[exp_addr] = 1'b0;
        outputs++;
      end
    end
    stall_q   = rst_ni && o_out_valid && !i_out_ready;
    stall_rsp = o_out_rsp;
  end

  //////////////////////
  // Stimulus
  //////////////////////

  initial begin
    logic [31:0] r;
    int          id;
    rand_state   = 32'd92914;
    errors       = 0;
    checks       = 0;
    outputs      = 0;
    seq_ctr      = 0;
    stall_q      = 1'b0;
    i_rsv        = '0;
    i_in_rsp     = '0;
    i_in_valid   = 1'b0;
    i_release_en = '0;
    i_out_ready  = 1'b1;
    rst_ni       = 1'b0;
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    @(negedge clk_i);
    expect_true(!o_out_valid && o_released_onehot == '0, "output active after reset");
    expect_true(o_rsv_ready && o_rsv_iid == '0, "reservation side not idle after reset");
    step();

    // A response with no open reservation must be refused
    i_in_rsp   = '{id: `RB_ID_W'(2), payload: `RB_PAYLOAD_W'(1)};
    i_in_valid = 1'b1;
    @(negedge clk_i);
    expect_true(!o_in_ready, "response accepted with no open reservation");
    step();
    i_in_valid = 1'b0;

    // Fill the whole pool with two cells per identifier
    for (int k = 0; k < `RB_DEPTH; k++) begin
      reserve(k % `RB_NUM_IDS);
    end
    @(negedge clk_i);
    expect_true(!o_rsv_ready, "o_rsv_ready high with every cell reserved");
    step();
    for (int k = 0; k < `RB_DEPTH; k++) begin
      r = xorshift32();
      send_rsp((`RB_DEPTH - 1 - k) % `RB_NUM_IDS, r[`RB_PAYLOAD_W-1:0]);
    end

    // Nothing leaves while every release enable is low
    repeat (10) step();
    expect_true(outputs == 0 && !o_out_valid, "response left with its release enable low");

    // All identifiers become eligible at once and the lowest one goes first
    i_release_en = '1;
    do begin
      @(negedge clk_i);
    end while (!o_out_valid);
    expect_true(o_out_rsp.id == '0, $sformatf("first output has id %0d", o_out_rsp.id));
    while (busy_count() != 0) begin
      step();
    end
    step();

    // Random traffic with random release enables and back-pressure
    for (int n = 0; n < NUM_RAND; n++) begin
      r            = xorshift32();
      i_out_ready  = (r[1:0] != 2'b00);
      i_release_en = r[15:8] | r[23:16];
      i_rsv        = '0;
      if (r[4] && lowest_free() >= 0) begin
        i_rsv.id_onehot = `RB_NUM_IDS'(1) << r[7:6];
        i_rsv.valid     = 1'b1;
      end
      i_in_valid       = r[5] | r[28];
      i_in_rsp.id      = r[25:24];
      i_in_rsp.payload = r[27:26];
      step();
    end

    // Drain by answering every open reservation and releasing every cell
    i_rsv        = '0;
    i_release_en = '1;
    while (busy_count() != 0) begin
      r           = xorshift32();
      i_out_ready = r[0] | r[1];
      i_in_valid  = 1'b0;
      for (int i = `RB_NUM_IDS - 1; i >= 0; i--) begin
        if (oldest_cell(i, 1'b1) >= 0) begin
          id         = i;
          i_in_valid = 1'b1;
        end
      end
      i_in_rsp.id      = `RB_ID_W'(id);
      i_in_rsp.payload = r[3:2];
      step();
    end
    i_in_valid  = 1'b0;
    i_out_ready = 1'b1;
    @(negedge clk_i);
    expect_true(o_rsv_ready && !o_out_valid, "bank not empty after draining all cells");

    $display("Checks %0d, errors %0d, outputs %0d", checks, errors, outputs);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
